/* tb.f */
+incdir+common
common/pipeTypesPkg.sv
common/pipeCtrlPkg.sv
common/hazardIf.sv
src/pipeStageReg.sv
src/hazardDetect.sv
src/mulDivUnit.sv
wrFlushControl/wrFlushControl.sv
src/pipeTop.sv
bench/pipe_assert.sv
bench/tb_pipeTop.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the pipeline testbench with Verilator
# exits with 0 only when the testbench prints its pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_pipeTop -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/Vtb_pipeTop)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qxF -- '>>> PASS'; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* bench/tb_pipeTop.sv */
// directed testbench for the six-stage pipeline top level
// issues tokens through the four-phase entry handshake and keeps
// a queue of expected retirements and exceptions
// a negedge monitor compares every retirement and exception pulse
`timescale 1ns/1ps
`include "pipe_defines.svh"

module tb_pipeTop;
    import pipeTypesPkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int RST_CYCLES      = 16;
    localparam int DRIVE_DELAY     = 2;   // inputs change this long after the edge
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;

    logic              clk;
    logic              rst;
    logic              inReq;
    logic [`TAG_W-1:0] inTag;
    opKind_t           inKind;
    logic [`REG_W-1:0] inDst;
    logic [`REG_W-1:0] inSrcA;
    logic [`REG_W-1:0] inSrcB;
    logic [`OPD_W-1:0] inOpA;
    logic [`OPD_W-1:0] inOpB;
    logic              inMispredict;
    logic              inRaiseExc;
    logic              inAck;
    logic              icacheBusy;
    logic              dcacheBusy;
    logic              retValid;
    logic [`TAG_W-1:0] retTag;
    logic [RES_W-1:0]  retResult;
    logic              excValid;
    logic [`TAG_W-1:0] excTag;
    logic              cacheBusy;

    int                seed = 32'h52f5;
    logic [`TAG_W-1:0] nextTag;
    logic              excPending;  // fault accepted, report not seen yet
    logic              ackPrev;
    logic              busyPrev;
    logic [`TAG_W-1:0] expTag[$];   // retirements in issue order
    logic [RES_W-1:0]  expRes[$];
    logic [`TAG_W-1:0] expExcTag[$];

    assign cacheBusy = icacheBusy || dcacheBusy;

    pipeTop i_dut (
        .clk(clk), .rst(rst), .inReq(inReq), .inTag(inTag), .inKind(inKind),
        .inDst(inDst), .inSrcA(inSrcA), .inSrcB(inSrcB), .inOpA(inOpA), .inOpB(inOpB),
        .inMispredict(inMispredict), .inRaiseExc(inRaiseExc), .inAck(inAck),
        .icacheBusy(icacheBusy), .dcacheBusy(dcacheBusy), .retValid(retValid),
        .retTag(retTag), .retResult(retResult), .excValid(excValid), .excTag(excTag)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // advance to just after the next rising edge
    task automatic nextCycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // result rule of EXE: product for multiplies, sum for all else
    function automatic logic [RES_W-1:0] expectedResult(input opKind_t kind,
            input logic [`OPD_W-1:0] a, input logic [`OPD_W-1:0] b);
        if (kind == OP_MUL) begin
            return RES_W'(a) * RES_W'(b);
        end
        return RES_W'(a) + RES_W'(b);
    endfunction

    task automatic checkRet(input logic [`TAG_W-1:0] tag, input logic [RES_W-1:0] result);
        logic [`TAG_W-1:0] wantTag;
        logic [RES_W-1:0]  wantRes;
        if (expTag.size() == 0) begin
            abortRun($sformatf("token %h retired while no retirement was expected", tag));
        end
        wantTag = expTag.pop_front();
        wantRes = expRes.pop_front();
        if (tag !== wantTag) begin
            abortRun($sformatf("Error: retTag got %h expected %h", tag, wantTag));
        end
        if (result !== wantRes) begin
            abortRun($sformatf("Error: retResult got %h expected %h (tag %h)",
                               result, wantRes, tag));
        end
    endtask

    task automatic checkExc(input logic [`TAG_W-1:0] tag);
        logic [`TAG_W-1:0] wantTag;
        if (expExcTag.size() == 0) begin
            abortRun($sformatf("exception reported for tag %h but none was expected", tag));
        end
        wantTag = expExcTag.pop_front();
        if (tag !== wantTag) begin
            abortRun($sformatf("Error: excTag got %h expected %h", tag, wantTag));
        end
    endtask

    // one token through req/ack, operands random
    task automatic issueTok(input opKind_t kind, input logic [`REG_W-1:0] dst,
                            input logic [`REG_W-1:0] srcA, input logic [`REG_W-1:0] srcB,
                            input logic mispredict, input logic exc, input logic retires);
        logic [`OPD_W-1:0] a;
        logic [`OPD_W-1:0] b;
        a = `OPD_W'($random(seed));
        b = `OPD_W'($random(seed));
        inTag        = nextTag;
        inKind       = kind;
        inDst        = dst;
        inSrcA       = srcA;
        inSrcB       = srcB;
        inOpA        = a;
        inOpB        = b;
        inMispredict = mispredict;
        inRaiseExc   = exc;
        inReq        = 1'b1;
        nextCycle();
        while (!inAck) begin
            nextCycle();
        end
        if (exc) begin
            expExcTag.push_back(nextTag); // reported, never retired
            excPending = 1'b1;
        end else if (retires && !excPending) begin
            expTag.push_back(nextTag);
            expRes.push_back(expectedResult(kind, a, b));
        end
        inReq = 1'b0;
        nextTag++;
        nextCycle();
        while (inAck) begin
            nextCycle();
        end
    endtask

    task automatic waitDrain();
        while (expTag.size() != 0 || expExcTag.size() != 0) begin
            nextCycle();
        end
        repeat (8) nextCycle(); // room for a stray pulse
    endtask

    task automatic addBackToBack();
        int i;
        for (i = 0; i < 8; i++) begin
            issueTok(OP_ADD, `REG_W'(i + 1), 5'd2, 5'd3, 1'b0, 1'b0, 1'b1);
        end
        waitDrain();
    endtask

    task automatic mulThenYounger();
        issueTok(OP_MUL, 5'd4, 5'd1, 5'd2, 1'b0, 1'b0, 1'b1);
        issueTok(OP_ADD, 5'd5, 5'd1, 5'd2, 1'b0, 1'b0, 1'b1);
        issueTok(OP_ADD, 5'd6, 5'd7, 5'd8, 1'b0, 1'b0, 1'b1);
        issueTok(OP_ADD, 5'd9, 5'd3, 5'd1, 1'b0, 1'b0, 1'b1);
        waitDrain();
    endtask

    // the multiply in front lines up load and consumer back to back
    task automatic loadUse();
        issueTok(OP_MUL, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0, 1'b1);
        issueTok(OP_LOAD, 5'd5, 5'd2, 5'd3, 1'b0, 1'b0, 1'b1);
        issueTok(OP_ADD, 5'd6, 5'd5, 5'd7, 1'b0, 1'b0, 1'b1); // reads r5
        issueTok(OP_ADD, 5'd8, 5'd9, 5'd5, 1'b0, 1'b0, 1'b1);
        waitDrain();
    endtask

    task automatic mispredictAfterMul();
        issueTok(OP_MUL, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0, 1'b1);
        issueTok(OP_BRANCH, 5'd0, 5'd4, 5'd5, 1'b1, 1'b0, 1'b1);
        issueTok(OP_ADD, 5'd6, 5'd2, 5'd3, 1'b0, 1'b0, 1'b0);  // wrong path, squashed
        issueTok(OP_ADD, 5'd7, 5'd2, 5'd3, 1'b0, 1'b0, 1'b1);
        issueTok(OP_ADD, 5'd8, 5'd2, 5'd3, 1'b0, 1'b0, 1'b1);
        waitDrain();
    endtask

    // tokens accepted before the report are dropped via excPending
    task automatic exceptionSquash();
        issueTok(OP_ADD, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0, 1'b1);
        issueTok(OP_ADD, 5'd4, 5'd2, 5'd3, 1'b0, 1'b1, 1'b0);  // faults in MEM
        issueTok(OP_ADD, 5'd5, 5'd2, 5'd3, 1'b0, 1'b0, 1'b1);
        issueTok(OP_ADD, 5'd6, 5'd2, 5'd3, 1'b0, 1'b0, 1'b1);
        issueTok(OP_ADD, 5'd7, 5'd2, 5'd3, 1'b0, 1'b0, 1'b1);
        waitDrain();
    endtask

    task automatic busyBursts(input int bursts);
        int   i;
        int   gap;
        int   len;
        logic pickI;
        for (i = 0; i < bursts; i++) begin
            gap   = 1 + ($random(seed) & 3);
            len   = 1 + ($random(seed) & 7);
            pickI = ($random(seed) & 1) != 0;
            repeat (gap) nextCycle();
            icacheBusy = pickI;
            dcacheBusy = !pickI;
            repeat (len) nextCycle();
            icacheBusy = 1'b0;
            dcacheBusy = 1'b0;
        end
    endtask

    task automatic cacheBusyBursts();
        int i;
        fork
            busyBursts(6);
            begin
                for (i = 0; i < 6; i++) begin
                    issueTok(OP_ADD, `REG_W'(i + 10), 5'd2, 5'd3, 1'b0, 1'b0, 1'b1);
                end
            end
        join
        waitDrain();
    endtask

    // mid-cycle monitor, all inputs settled by now
    always @(negedge clk) begin
        if (!rst) begin
            if (retValid && cacheBusy) begin
                abortRun("retirement pulse while a cache was busy");
            end
            if (inAck && !ackPrev && busyPrev) begin
                abortRun("inAck rose after a cycle with a busy cache");
            end
            if (retValid) begin
                checkRet(retTag, retResult);
            end
            if (excValid) begin
                checkExc(excTag);
                excPending = 1'b0;
            end
        end
        ackPrev  = inAck;
        busyPrev = cacheBusy;
    end

    // watchdog
    initial begin
        repeat (RST_CYCLES + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        abortRun("watchdog expired before the tests finished");
    end

    initial begin
        rst          = 1'b1;
        inReq        = 1'b0;
        inTag        = '0;
        inKind       = OP_ADD;
        inDst        = '0;
        inSrcA       = '0;
        inSrcB       = '0;
        inOpA        = '0;
        inOpB        = '0;
        inMispredict = 1'b0;
        inRaiseExc   = 1'b0;
        icacheBusy   = 1'b0;
        dcacheBusy   = 1'b0;
        nextTag      = 8'h10;
        excPending   = 1'b0;
        ackPrev      = 1'b0;
        busyPrev     = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        nextCycle();
        addBackToBack();
        mulThenYounger();
        loadUse();
        mispredictAfterMul();
        exceptionSquash();
        cacheBusyBursts();
        if (expTag.size() == 0 && expExcTag.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abortRun("expected retirements or exceptions never arrived");
        end
    end

endmodule

/* bench/pipe_assert.sv */
// protocol and control checks on the pipeline top level
// bound into pipeTop, covers entry handshake, cache freeze and mul abort
`timescale 1ns/1ps

module pipeAssert (
    input logic                   clk,
    input logic                   rst,
    input logic                   inReq,
    input logic                   inAck,
    input logic                   icacheBusy,
    input logic                   dcacheBusy,
    input pipeCtrlPkg::stageVec_t wrEn,
    input logic                   retValid,
    input logic                   mulAbort,  // same as an exception in MEM
    input logic                   mulBusy
);

    logic cacheBusy;

    assign cacheBusy = icacheBusy || dcacheBusy;

    // ack only answers a request
    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(inAck) |-> $past(inReq))
        else $error("inAck rose without inReq");

    // caches freeze the whole pipe unless an exception flushes it
    busyFreezes: assert property (@(posedge clk) disable iff (rst)
        (cacheBusy && !mulAbort) |-> (wrEn == '0))
        else $error("stage write enable set while a cache was busy");

    busyNoRetire: assert property (@(posedge clk) disable iff (rst)
        cacheBusy |-> !retValid)
        else $error("retValid high while a cache was busy");

    abortStopsMul: assert property (@(posedge clk) disable iff (rst)
        mulAbort |=> !mulBusy)
        else $error("multiplier still busy one cycle after abort");

endmodule

bind pipeTop pipeAssert pipeChecks (
    .clk(clk), .rst(rst), .inReq(inReq), .inAck(inAck),
    .icacheBusy(icacheBusy), .dcacheBusy(dcacheBusy), .wrEn(wrEn),
    .retValid(retValid), .mulAbort(mulAbort), .mulBusy(mulBusyRaw)
);

/* src/pipeTop.sv */
// six-stage pipeline model, IF ID EXE MEM MEM2 WB
// tokens enter through a four-phase req/ack handshake into IF and
// leave WB as single-cycle retirement pulses
// EXE adds the operands or runs the iterative multiplier
// a faulting token in MEM is dropped and reported one cycle later
`timescale 1ns/1ps
`include "pipe_defines.svh"

module pipeTop (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            inReq,
    input  logic [`TAG_W-1:0]               inTag,
    input  pipeTypesPkg::opKind_t           inKind,
    input  logic [`REG_W-1:0]               inDst,
    input  logic [`REG_W-1:0]               inSrcA,
    input  logic [`REG_W-1:0]               inSrcB,
    input  logic [`OPD_W-1:0]               inOpA,
    input  logic [`OPD_W-1:0]               inOpB,
    input  logic                            inMispredict,
    input  logic                            inRaiseExc,
    output logic                            inAck,
    input  logic                            icacheBusy,
    input  logic                            dcacheBusy,
    output logic                            retValid,
    output logic [`TAG_W-1:0]               retTag,
    output logic [pipeTypesPkg::RES_W-1:0]  retResult,
    output logic                            excValid,
    output logic [`TAG_W-1:0]               excTag
);
    import pipeTypesPkg::*;
    import pipeCtrlPkg::*;

    hazardIf hz ();

    stageVec_t         wrEn;
    stageVec_t         flush;
    logic              mulAbort;
    logic              cacheBusy;
    logic              capture;    // token taken into IF this cycle
    logic              ifLoad;
    instr_t            inTok;
    instr_t            ifTok;
    instr_t            idTok;
    exeTok_t           exeIn;
    exeTok_t           exeTok;
    exeTok_t           exeOut;
    exeTok_t           memTok;
    exeTok_t           mem2Tok;
    exeTok_t           wbTok;
    logic              ifValid;
    logic              idValid;
    logic              exeValid;
    logic              memValid;
    logic              mem2Valid;
    logic              wbValid;
    logic              ifPass;     // token handed to the next stage
    logic              idPass;
    logic              exePass;
    logic              memPass;
    logic              mem2Pass;
    logic              exeIsMul;
    logic              mulStart;
    logic              mulIssued;  // EXE multiply already started
    logic              mulBusyRaw;
    logic              mulDone;
    logic [RES_W-1:0]  mulProduct;

    assign cacheBusy = icacheBusy || dcacheBusy;

    always_comb begin
        inTok.tag          = inTag;
        inTok.opKind       = inKind;
        inTok.dst          = inDst;
        inTok.srcA         = inSrcA;
        inTok.srcB         = inSrcB;
        inTok.opA          = inOpA;
        inTok.opB          = inOpB;
        inTok.isMispredict = inMispredict;
        inTok.raiseExc     = inRaiseExc;
    end

    // entry: one capture per request, IF must be free or moving
    assign capture = inReq && !inAck && !cacheBusy && !flush[ST_IF]
                     && (!ifValid || wrEn[ST_IF]);
    assign ifLoad  = wrEn[ST_IF] || !ifValid; // empty IF may fill while stalled

    // ack rises after the capture and drops once req is gone
    always_ff @(posedge clk) begin
        if (rst) begin
            inAck <= 1'b0;
        end else if (capture) begin
            inAck <= 1'b1;
        end else if (!inReq) begin
            inAck <= 1'b0;
        end
    end

    // hand-over between stages, a flushed stage passes nothing on
    assign ifPass   = ifValid && wrEn[ST_IF] && !flush[ST_IF];
    assign idPass   = idValid && wrEn[ST_ID] && !flush[ST_ID];
    assign exePass  = exeValid && wrEn[ST_EXE]; // EXE flush is the bubble behind it
    assign memPass  = memValid && wrEn[ST_MEM] && !flush[ST_MEM]; // faulting token dies
    assign mem2Pass = mem2Valid && wrEn[ST_MEM2] && !flush[ST_MEM2];

    // adder at the EXE input, the sum rides in the result field
    always_comb begin
        exeIn.tok    = idTok;
        exeIn.result = RES_W'(idTok.opA) + RES_W'(idTok.opB);
    end

    // multiply result replaces the sum on the way out of EXE
    always_comb begin
        exeOut.tok    = exeTok.tok;
        exeOut.result = (exeIsMul && mulDone) ? mulProduct : exeTok.result;
    end

    pipeStageReg #(.payload_t(instr_t)) ifReg (
        .clk(clk), .rst(rst), .wrEn(ifLoad), .flush(flush[ST_IF]),
        .dIn(inTok), .dValid(capture), .q(ifTok), .qValid(ifValid)
    );

    pipeStageReg #(.payload_t(instr_t)) idReg (
        .clk(clk), .rst(rst), .wrEn(wrEn[ST_ID]), .flush(flush[ST_ID]),
        .dIn(ifTok), .dValid(ifPass), .q(idTok), .qValid(idValid)
    );

    pipeStageReg #(.payload_t(exeTok_t)) exeReg (
        .clk(clk), .rst(rst), .wrEn(wrEn[ST_EXE]), .flush(flush[ST_EXE]),
        .dIn(exeIn), .dValid(idPass), .q(exeTok), .qValid(exeValid)
    );

    pipeStageReg #(.payload_t(exeTok_t)) memReg (
        .clk(clk), .rst(rst), .wrEn(wrEn[ST_MEM]), .flush(flush[ST_MEM]),
        .dIn(exeOut), .dValid(exePass), .q(memTok), .qValid(memValid)
    );

    pipeStageReg #(.payload_t(exeTok_t)) mem2Reg (
        .clk(clk), .rst(rst), .wrEn(wrEn[ST_MEM2]), .flush(flush[ST_MEM2]),
        .dIn(memTok), .dValid(memPass), .q(mem2Tok), .qValid(mem2Valid)
    );

    pipeStageReg #(.payload_t(exeTok_t)) wbReg (
        .clk(clk), .rst(rst), .wrEn(wrEn[ST_WB]), .flush(flush[ST_WB]),
        .dIn(mem2Tok), .dValid(mem2Pass), .q(wbTok), .qValid(wbValid)
    );

    // multiplier, started once per EXE multiply token
    assign exeIsMul = (exeTok.tok.opKind == OP_MUL);
    assign mulStart = exeValid && exeIsMul && !mulIssued && !hz.excMem;

    always_ff @(posedge clk) begin
        if (rst) begin
            mulIssued <= 1'b0;
        end else if (wrEn[ST_EXE] || flush[ST_EXE]) begin
            mulIssued <= 1'b0; // EXE takes a new token
        end else if (mulStart) begin
            mulIssued <= 1'b1;
        end
    end

    mulDivUnit mulUnit (
        .clk(clk), .rst(rst), .start(mulStart), .abort(mulAbort),
        .opA(exeTok.tok.opA), .opB(exeTok.tok.opB),
        .busy(mulBusyRaw), .done(mulDone), .product(mulProduct)
    );

    hazardDetect hazardDet (
        .idTok(idTok), .idValid(idValid),
        .exeTok(exeTok), .exeValid(exeValid),
        .hz(hz.src)
    );

    // remaining hazard sources
    assign hz.mulBusy      = mulBusyRaw || mulStart; // EXE holds from the start cycle
    assign hz.excMem       = memValid && memTok.tok.raiseExc;
    assign hz.icacheBusy   = icacheBusy;
    assign hz.dcacheBusy   = dcacheBusy;
    // mispredict counts only when the branch actually leaves ID
    assign hz.branchFailed = idValid && (idTok.opKind == OP_BRANCH) && idTok.isMispredict
                             && !cacheBusy && !hz.dhStall && !hz.mulBusy;

    wrFlushControl ctrl (
        .hz(hz.ctrl), .wrEn(wrEn), .flush(flush), .mulAbort(mulAbort)
    );

    // retirement, one pulse as the WB token leaves
    assign retValid  = wbValid && wrEn[ST_WB];
    assign retTag    = wbTok.tok.tag;
    assign retResult = wbTok.result;

    // exception report, one cycle after MEM
    always_ff @(posedge clk) begin
        if (rst) begin
            excValid <= 1'b0;
        end else begin
            excValid <= hz.excMem;
        end
    end

    always_ff @(posedge clk) begin
        if (hz.excMem) begin
            excTag <= memTok.tok.tag;
        end
    end

endmodule

/* wrFlushControl/wrFlushControl.sv */
// stall and flush control for the six-stage pipeline
// turns the hazard sources into one write enable and one flush per
// stage, plus the multiplier abort
// priority: exception, cache busy, load-use, multiplier, mispredict
`timescale 1ns/1ps

module wrFlushControl (
    hazardIf.ctrl                  hz,
    output pipeCtrlPkg::stageVec_t wrEn,
    output pipeCtrlPkg::stageVec_t flush,
    output logic                   mulAbort
);
    import pipeCtrlPkg::*;

    logic cacheBusy;
    logic frontWr;  // IF and ID always move together
    logic exeWr;
    logic tailWr;   // MEM, MEM2 and WB
    logic ifFlush;
    logic exeFlush;

    assign cacheBusy = hz.icacheBusy || hz.dcacheBusy; // TLB stall already inside

    // IF / ID enable
    always_comb begin
        if (hz.excMem) begin
            frontWr = 1'b1;  // flushed anyway, keep moving
        end else if (cacheBusy) begin
            frontWr = 1'b0;
        end else if (hz.dhStall) begin
            frontWr = 1'b0;  // hold consumer in ID
        end else if (hz.mulBusy) begin
            frontWr = 1'b0;
        end else begin
            frontWr = 1'b1;  // mispredict included
        end
    end

    // EXE enable
    always_comb begin
        if (hz.excMem) begin
            exeWr = 1'b1;
        end else if (cacheBusy) begin
            exeWr = 1'b0;
        end else if (hz.dhStall) begin
            exeWr = 1'b1;    // load moves on, bubble comes in
        end else if (hz.mulBusy) begin
            exeWr = 1'b0;    // hold the multiply in EXE
        end else begin
            exeWr = 1'b1;
        end
    end

    // back end only stops for the caches
    always_comb begin
        if (hz.excMem) begin
            tailWr = 1'b1;   // older tokens keep retiring
        end else if (cacheBusy) begin
            tailWr = 1'b0;
        end else begin
            tailWr = 1'b1;
        end
    end

    // IF flush
    always_comb begin
        if (hz.excMem) begin
            ifFlush = 1'b1;
        end else if (cacheBusy || hz.dhStall || hz.mulBusy) begin
            ifFlush = 1'b0;  // branch cannot leave ID yet
        end else if (hz.branchFailed) begin
            ifFlush = 1'b1;  // wrong-path token in IF
        end else begin
            ifFlush = 1'b0;
        end
    end

    // EXE flush
    always_comb begin
        if (hz.excMem) begin
            exeFlush = 1'b1;
        end else if (cacheBusy) begin
            exeFlush = 1'b0; // load-use waits for the caches
        end else if (hz.dhStall) begin
            exeFlush = 1'b1; // bubble behind the load
        end else begin
            exeFlush = 1'b0;
        end
    end

    always_comb begin
        wrEn           = '0;
        wrEn[ST_IF]    = frontWr;
        wrEn[ST_ID]    = frontWr;
        wrEn[ST_EXE]   = exeWr;
        wrEn[ST_MEM]   = tailWr;
        wrEn[ST_MEM2]  = tailWr;
        wrEn[ST_WB]    = tailWr;

        flush          = '0;     // MEM2 and WB never flush
        flush[ST_IF]   = ifFlush;
        flush[ST_ID]   = hz.excMem;
        flush[ST_EXE]  = exeFlush;
        flush[ST_MEM]  = hz.excMem;
    end

    // kill the multiplier together with the EXE token
    assign mulAbort = hz.excMem;

endmodule

/* src/mulDivUnit.sv */
// iterative shift-add multiplier
// one multiplier bit per cycle over MUL_CYCLES cycles
// busy is high from the edge after start until the last step
// done then holds with the product until the next start
// abort drops the running operation at the next edge
`timescale 1ns/1ps
`include "pipe_defines.svh"

module mulDivUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,   // sampled while idle
    input  logic                  abort,   // exception kill
    input  logic [`OPD_W-1:0]     opA,
    input  logic [`OPD_W-1:0]     opB,
    output logic                  busy,
    output logic                  done,
    output logic [2*`OPD_W-1:0]   product
);

    localparam int CNT_W = $clog2(`MUL_CYCLES + 1);

    logic [CNT_W-1:0]     cnt;   // steps left
    logic [2*`OPD_W-1:0]  mcand; // shifted multiplicand
    logic [`OPD_W-1:0]    mplr;  // multiplier, consumed lsb first
    logic                 take;  // accept a new operation

    assign take = start && !busy && !abort;

    // sequencing
    always_ff @(posedge clk) begin
        if (rst || abort) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (take) begin
            busy <= 1'b1;
            done <= 1'b0;
            cnt  <= CNT_W'(`MUL_CYCLES);
        end else if (busy) begin
            cnt <= cnt - 1'b1;
            if (cnt == CNT_W'(1)) begin // last step
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (take) begin
            mcand   <= {{`OPD_W{1'b0}}, opA};
            mplr    <= opB;
            product <= '0;
        end else if (busy) begin
            if (mplr[0]) begin
                product <= product + mcand; // partial product
            end
            mcand <= mcand << 1;
            mplr  <= mplr >> 1;
        end
    end

endmodule

/* src/hazardDetect.sv */
// load-use hazard detection
// a valid load in EXE whose destination is read by the valid ID
// token stalls the front end for one cycle
`timescale 1ns/1ps

module hazardDetect (
    input  pipeTypesPkg::instr_t  idTok,
    input  logic                  idValid,
    input  pipeTypesPkg::exeTok_t exeTok,
    input  logic                  exeValid,
    hazardIf.src                  hz
);
    import pipeTypesPkg::*;

    logic exeLoad; // EXE holds a load that writes a real register
    logic hitA;
    logic hitB;

    assign exeLoad = exeValid && (exeTok.tok.opKind == OP_LOAD)
                     && (exeTok.tok.dst != '0); // r0 writes are dropped

    // every kind reads both sources
    assign hitA = (idTok.srcA == exeTok.tok.dst);
    assign hitB = (idTok.srcB == exeTok.tok.dst);

    // only dhStall comes from here, the rest of src is driven at the top
    assign hz.dhStall = exeLoad && idValid && (hitA || hitB);

endmodule

/* src/pipeStageReg.sv */
// pipeline stage register with valid bit
// flush empties the stage and wins over the write enable
// payload type chosen per stage
`timescale 1ns/1ps

module pipeStageReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wrEn,   // load dIn and dValid
    input  logic     flush,  // insert a bubble
    input  payload_t dIn,
    input  logic     dValid,
    output payload_t q,
    output logic     qValid
);

    // valid bit is the only control state
    always_ff @(posedge clk) begin
        if (rst) begin
            qValid <= 1'b0;
        end else if (flush) begin
            qValid <= 1'b0; // squashed
        end else if (wrEn) begin
            qValid <= dValid;
        end
    end

    // payload only follows a real write
    always_ff @(posedge clk) begin
        if (wrEn && !flush) begin
            q <= dIn;
        end
    end

endmodule

/* common/hazardIf.sv */
// hazard sources on their way to the write/flush controller
// src side is shared by the load-use detector and the top level
// ctrl side is read by wrFlushControl
`timescale 1ns/1ps

interface hazardIf;

    logic dhStall;      // load-use, from hazardDetect
    logic mulBusy;      // multiplier running or starting
    logic branchFailed; // mispredicted branch leaving ID
    logic excMem;       // faulting token in MEM
    logic icacheBusy;   // i-side stall, TLB folded in
    logic dcacheBusy;   // d-side stall, TLB folded in

    modport src (
        output dhStall, mulBusy, branchFailed,
        output excMem, icacheBusy, dcacheBusy
    );

    modport ctrl (
        input dhStall, mulBusy, branchFailed,
        input excMem, icacheBusy, dcacheBusy
    );

endinterface

/* common/pipeCtrlPkg.sv */
// pipeline control types
// stage index names and the per-stage enable and flush vectors
package pipeCtrlPkg;

    localparam int NUM_STAGES = 6;

    // bit positions inside a stageVec_t
    typedef enum logic [2:0] {
        ST_IF   = 3'd0,
        ST_ID   = 3'd1,
        ST_EXE  = 3'd2,
        ST_MEM  = 3'd3,
        ST_MEM2 = 3'd4,
        ST_WB   = 3'd5
    } stageIdx_t;

    // one bit per stage, IF in bit 0
    typedef logic [NUM_STAGES-1:0] stageVec_t;

endpackage

/* common/pipeTypesPkg.sv */
// token payload types
// instr_t enters IF and moves through IF and ID
// exeTok_t adds the EXE result and is carried from EXE to WB
`include "pipe_defines.svh"

package pipeTypesPkg;

    localparam int RES_W = 2 * `OPD_W; // full product width

    // operation kind of a token
    typedef enum logic [1:0] {
        OP_ADD    = 2'd0,
        OP_MUL    = 2'd1,
        OP_LOAD   = 2'd2, // sum is the address
        OP_BRANCH = 2'd3
    } opKind_t;

    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        opKind_t           opKind;
        logic [`REG_W-1:0] dst;
        logic [`REG_W-1:0] srcA;
        logic [`REG_W-1:0] srcB;
        logic [`OPD_W-1:0] opA;
        logic [`OPD_W-1:0] opB;
        logic              isMispredict; // only meaningful for branches
        logic              raiseExc;     // faults when it reaches MEM
    } instr_t;

    // token after EXE, result is sum or product
    typedef struct packed {
        instr_t           tok;
        logic [RES_W-1:0] result;
    } exeTok_t;

endpackage

/* common/pipe_defines.svh */
// pipeline widths and multiplier timing
// shared by the packages, the RTL and the bench
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// token tag, echoed on retirement and exception
`define TAG_W 8

// operand width, the result is twice this
`define OPD_W 16

`define REG_W 5 // register number, r0 never conflicts

// shift-add steps of the multiplier, one bit per cycle
// must cover every operand bit
`define MUL_CYCLES 16

`endif
